//--- include/mul_settings.svh
`ifndef MUL_SETTINGS_SVH
`define MUL_SETTINGS_SVH

// operand width, the compressor tree is built for 8 rows
`define OP_WIDTH 8

// one mask bit per configurable adder column (5..11)
`define ER_WIDTH 7

// stage registers between operand capture and result
`define PIPE_DEPTH 3

`endif

//--- logic/mulPkg.sv
`include "mul_settings.svh"

package mulPkg;

    // one unsigned multiplier operand
    typedef logic [`OP_WIDTH-1:0] operandT;

    // full product, two operand widths
    typedef logic [2*`OP_WIDTH-1:0] productT;

    // accuracy mask
    // bit i set makes adder column 5+i exact, clear makes it approximate
    typedef logic [`ER_WIDTH-1:0] erMaskT;

    // second level compressed rows p5 and p6
    // 8-bit rows grow by 1 then by 2 bits through the two compressor levels
    typedef logic [`OP_WIDTH+2:0] compRowT;

    // leftover rows v1 and v2, and the sum and carry vectors
    typedef logic [2*`OP_WIDTH-2:0] leftoverT;

endpackage

//--- logic/iCac.sv
`timescale 1ns/100ps

// approximate two-row compressor
// d2 sits shiftBits columns above d1; where both rows overlap the OR goes
// to p and the AND leftover goes to q
module iCac
#(
    parameter int dWidth    = 8,
    parameter int shiftBits = 1
)
(
    input  logic [dWidth-1:0]           d1,
    input  logic [dWidth-1:0]           d2,
    output logic [dWidth+shiftBits-1:0] p,
    output logic [dWidth+shiftBits-1:0] q
);

    localparam int oWidth = dWidth + shiftBits;

    logic [oWidth-1:0] d1Ext;
    logic [oWidth-1:0] d2Shift;

    assign d1Ext   = {{shiftBits{1'b0}}, d1};
    assign d2Shift = {d2, {shiftBits{1'b0}}};

    // outside the overlap one row is zero, so OR passes the other through
    assign p = d1Ext | d2Shift;
    assign q = d1Ext & d2Shift;  // zero outside the overlap

endmodule

//--- logic/ppCompressor.sv
`timescale 1ns/100ps
`include "mul_settings.svh"

module ppCompressor
    import mulPkg::*;
(
    input  logic     CLK,
    input  logic     rstN,
    input  logic     inValid,
    input  operandT  operandA,
    input  operandT  operandB,
    input  erMaskT   erMask,
    output compRowT  p5Q,
    output compRowT  p6Q,
    output leftoverT v1Q,
    output leftoverT v2Q,
    output logic     validQ,
    output erMaskT   erMaskQ
);

    operandT ppRow [`OP_WIDTH];

    // first compressor level, 9-bit rows
    logic [`OP_WIDTH:0] pRow [4];
    logic [`OP_WIDTH:0] qRow [4];

    compRowT  p5;
    compRowT  p6;
    compRowT  q5;
    compRowT  q6;
    leftoverT v1;
    leftoverT v2;

    for (genvar j = 0; j < `OP_WIDTH; j++)
    begin : genPp
        assign ppRow[j] = operandA & {`OP_WIDTH{operandB[j]}};
    end

    // rows 0-1, 2-3, 4-5, 6-7
    for (genvar k = 0; k < 4; k++)
    begin : genCacL1
        iCac #(
            .dWidth    (`OP_WIDTH),
            .shiftBits (1)
        ) uCac (
            .d1 (ppRow[2*k]),
            .d2 (ppRow[2*k+1]),
            .p  (pRow[k]),
            .q  (qRow[k])
        );
    end

    // each pair starts two columns above the previous one
    always_comb
    begin
        v1 = '0;
        for (int k = 0; k < 4; k++)
        begin
            v1 = v1 | (leftoverT'(qRow[k]) << (2 * k));
        end
    end

    iCac #(
        .dWidth    (`OP_WIDTH + 1),
        .shiftBits (2)
    ) uCac5 (
        .d1 (pRow[0]),
        .d2 (pRow[1]),
        .p  (p5),
        .q  (q5)
    );

    iCac #(
        .dWidth    (`OP_WIDTH + 1),
        .shiftBits (2)
    ) uCac6 (
        .d1 (pRow[2]),
        .d2 (pRow[3]),
        .p  (p6),
        .q  (q6)
    );

    assign v2 = leftoverT'(q5) | (leftoverT'(q6) << 4);  // p6 sits 4 columns up

    always_ff @(posedge CLK or negedge rstN)
    begin
        if (!rstN)
            validQ <= 1'b0;
        else
            validQ <= inValid;
    end

    always_ff @(posedge CLK)
    begin
        if (inValid)
        begin
            p5Q     <= p5;
            p6Q     <= p6;
            v1Q     <= v1;
            v2Q     <= v2;
            erMaskQ <= erMask;  // mask rides along with its operands
        end
    end

endmodule

//--- logic/csReducer.sv
`timescale 1ns/100ps
`include "mul_settings.svh"

module csReducer
    import mulPkg::*;
(
    input  logic     CLK,
    input  logic     rstN,
    input  logic     validIn,
    input  compRowT  p5,
    input  compRowT  p6,
    input  leftoverT v1,
    input  leftoverT v2,
    input  erMaskT   erMaskIn,
    output leftoverT sumQ,
    output leftoverT carryQ,
    output logic     validQ,
    output erMaskT   erMaskQ
);

    leftoverT p7;
    leftoverT q7;
    leftoverT sumVec;
    leftoverT carryVec;

    iCac #(
        .dWidth    (`OP_WIDTH + 3),
        .shiftBits (4)
    ) uCac7 (
        .d1 (p5),
        .d2 (p6),
        .p  (p7),
        .q  (q7)
    );

    // one adder per column, carry lands one column up
    // a half adder is a full adder with its third input tied low
    always_comb
    begin
        logic inB;
        logic inC;

        sumVec   = '0;
        carryVec = '0;
        sumVec[0] = p7[0];

        for (int i = 1; i < 2*`OP_WIDTH-2; i++)
        begin
            if (i == 1 || i == 2*`OP_WIDTH-3)
            begin
                inB = v1[i];  // half adder columns
                inC = 1'b0;
            end
            else if (i >= 4 && i <= `OP_WIDTH+2)
            begin
                inB = q7[i];
                inC = v1[i] | v2[i];
            end
            else
            begin
                inB = v1[i];
                inC = v2[i];
            end

            sumVec[i]     = p7[i] ^ inB ^ inC;
            carryVec[i+1] = (p7[i] & inB) | (p7[i] & inC) | (inB & inC);
        end

        sumVec[2*`OP_WIDTH-2] = p7[2*`OP_WIDTH-2];  // top column, nothing to add
    end

    always_ff @(posedge CLK or negedge rstN)
    begin
        if (!rstN)
            validQ <= 1'b0;
        else
            validQ <= validIn;
    end

    always_ff @(posedge CLK)
    begin
        if (validIn)
        begin
            sumQ    <= sumVec;
            carryQ  <= carryVec;
            erMaskQ <= erMaskIn;
        end
    end

endmodule

//--- logic/ecAdder.sv
`timescale 1ns/100ps
`include "mul_settings.svh"

module ecAdder
    import mulPkg::*;
(
    input  logic     CLK,
    input  logic     rstN,
    input  logic     validIn,
    input  leftoverT sumIn,
    input  leftoverT carryIn,
    input  erMaskT   erMaskIn,
    output productT  result,
    output logic     outValid
);

    // columns 5..14, upper three always exact
    logic [`ER_WIDTH+2:0] exactCol;
    productT              resNext;

    assign exactCol = {3'b111, erMaskIn};

    always_comb
    begin
        logic cin;
        logic half;

        resNext = '0;
        resNext[1:0] = sumIn[1:0];
        resNext[4:2] = sumIn[4:2] | carryIn[4:2];  // carry into these columns dropped

        cin = 1'b0;
        for (int i = 5; i < 2*`OP_WIDTH-1; i++)
        begin
            half = sumIn[i] ^ carryIn[i];
            if (exactCol[i-5])
            begin
                resNext[i] = half ^ cin;
                cin = (sumIn[i] & carryIn[i]) | (half & cin);
            end
            else
            begin
                // cheap cell, wrong only when half and cin are both set
                resNext[i] = half | cin;
                cin = sumIn[i] & (carryIn[i] | cin);
            end
        end

        resNext[2*`OP_WIDTH-1] = cin;  // final carry out
    end

    always_ff @(posedge CLK or negedge rstN)
    begin
        if (!rstN)
            outValid <= 1'b0;
        else
            outValid <= validIn;
    end

    always_ff @(posedge CLK)
    begin
        if (validIn)
            result <= resNext;
    end

endmodule

//--- logic/approxMultiplier.sv
`timescale 1ns/100ps

module approxMultiplier
    import mulPkg::*;
(
    input  logic    CLK,
    input  logic    rstN,
    input  logic    inValid,
    input  operandT operandA,
    input  operandT operandB,
    input  erMaskT  erMask,
    output logic    outValid,
    output productT result
);

    compRowT  s1P5;
    compRowT  s1P6;
    leftoverT s1V1;
    leftoverT s1V2;
    logic     s1Valid;
    erMaskT   s1ErMask;

    leftoverT s2Sum;
    leftoverT s2Carry;
    logic     s2Valid;
    erMaskT   s2ErMask;

    ppCompressor uPpCompressor (
        .CLK      (CLK),
        .rstN     (rstN),
        .inValid  (inValid),
        .operandA (operandA),
        .operandB (operandB),
        .erMask   (erMask),
        .p5Q      (s1P5),
        .p6Q      (s1P6),
        .v1Q      (s1V1),
        .v2Q      (s1V2),
        .validQ   (s1Valid),
        .erMaskQ  (s1ErMask)
    );

    csReducer uCsReducer (
        .CLK      (CLK),
        .rstN     (rstN),
        .validIn  (s1Valid),
        .p5       (s1P5),
        .p6       (s1P6),
        .v1       (s1V1),
        .v2       (s1V2),
        .erMaskIn (s1ErMask),
        .sumQ     (s2Sum),
        .carryQ   (s2Carry),
        .validQ   (s2Valid),
        .erMaskQ  (s2ErMask)
    );

    ecAdder uEcAdder (
        .CLK      (CLK),
        .rstN     (rstN),
        .validIn  (s2Valid),
        .sumIn    (s2Sum),
        .carryIn  (s2Carry),
        .erMaskIn (s2ErMask),
        .result   (result),
        .outValid (outValid)
    );

endmodule

//--- tests/approxMultiplier_asserts.sv
`timescale 1ns/100ps
`include "mul_settings.svh"

module approxMultiplierAsserts
(
    input logic CLK,
    input logic rstN,
    input logic inValid,
    input logic outValid
);

    // strobes of the last PIPE_DEPTH cycles, cleared together with the DUT
    logic [`PIPE_DEPTH-1:0] strobeHist;

    always_ff @(posedge CLK or negedge rstN)
    begin
        if (!rstN)
            strobeHist <= '0;
        else
            strobeHist <= {strobeHist[`PIPE_DEPTH-2:0], inValid};
    end

    // each accepted strobe shows up PIPE_DEPTH cycles later, and nothing else does
    outValidFollowsStrobe: assert property (
        @(posedge CLK) disable iff (!rstN)
        outValid == strobeHist[`PIPE_DEPTH-1]
    ) else $error("outValid does not match the strobe of %0d cycles earlier", `PIPE_DEPTH);

    outValidHasStrobe: assert property (
        @(posedge CLK) disable iff (!rstN)
        outValid |-> $past(inValid, `PIPE_DEPTH)
    ) else $error("outValid high without a strobe %0d cycles earlier", `PIPE_DEPTH);

    outValidLowInReset: assert property (
        @(posedge CLK)
        !rstN |-> !outValid
    ) else $error("outValid high while reset is asserted");

endmodule

bind approxMultiplier approxMultiplierAsserts uAsserts (
    .CLK      (CLK),
    .rstN     (rstN),
    .inValid  (inValid),
    .outValid (outValid)
);

//--- tests/approxMultiplierTb.sv
`timescale 1ns/100ps
`include "mul_settings.svh"

module approxMultiplierTb
    import mulPkg::*;
();

    localparam int t1Ops = 200;
    localparam int t2Pairs = 100;
    localparam int t3Ops = 60;
    localparam int t4Cycles = 200;
    localparam int t5Ops = 12;
    // reset, every issue cycle and the idle cycles of the mid-stream reset test
    localparam int stimCycles = 2 + t1Ops + 2*t2Pairs + t3Ops + t4Cycles + t5Ops + 6;
    localparam int timeoutLimit = stimCycles + `PIPE_DEPTH + 50;  // drains fit in the margin

    typedef struct packed {
        productT     expVal;
        logic        zeroOp;
        logic [31:0] tag;
    } expEntryT;

    logic    CLK;
    logic    rstN;
    logic    inValid;
    operandT operandA;
    operandT operandB;
    erMaskT  erMask;
    logic    outValid;
    productT result;

    expEntryT expQ [$];
    integer   seed;
    int       errors = 0;
    int       checks = 0;
    int       cycles = 0;
    int       inCount = 0;
    int       outCount = 0;
    int       maxInFlight = 0;

    approxMultiplier uut (
        .CLK      (CLK),
        .rstN     (rstN),
        .inValid  (inValid),
        .operandA (operandA),
        .operandB (operandB),
        .erMask   (erMask),
        .outValid (outValid),
        .result   (result)
    );

    initial
    begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    function automatic logic [1:0] fullAdd(input logic x, input logic y, input logic z);
        return {1'b0, x} + {1'b0, y} + {1'b0, z};
    endfunction

    // compressor tree, column adders, then the mask-controlled ripple adder
    function automatic productT refProduct(input operandT a, input operandT b,
                                           input erMaskT mask);
        logic [8:0]  pk [4];
        logic [8:0]  qk [4];
        logic [10:0] p5;
        logic [10:0] q5;
        logic [10:0] p6;
        logic [10:0] q6;
        logic [14:0] v1;
        logic [14:0] v2;
        logic [14:0] p7;
        logic [14:0] q7;
        logic [14:0] s;
        logic [14:0] c;
        logic [14:5] exactCols;
        productT     r;
        logic [1:0]  fa;
        logic        y;
        logic        z;
        logic        cy;

        v1 = '0;
        for (int k = 0; k < 4; k++)
        begin
            pk[k] = {1'b0, a & {8{b[2*k]}}} | {a & {8{b[2*k+1]}}, 1'b0};
            qk[k] = {1'b0, a & {8{b[2*k]}}} & {a & {8{b[2*k+1]}}, 1'b0};
            v1 = v1 | (15'(qk[k]) << (2*k));
        end
        p5 = {2'b00, pk[0]} | {pk[1], 2'b00};
        q5 = {2'b00, pk[0]} & {pk[1], 2'b00};
        p6 = {2'b00, pk[2]} | {pk[3], 2'b00};
        q6 = {2'b00, pk[2]} & {pk[3], 2'b00};
        v2 = 15'(q5) | (15'(q6) << 4);
        p7 = {4'b0000, p5} | {p6, 4'b0000};
        q7 = {4'b0000, p5} & {p6, 4'b0000};

        s = '0;
        c = '0;
        s[0] = p7[0];
        s[14] = p7[14];
        for (int i = 1; i <= 13; i++)
        begin
            if (i == 1 || i == 13)
            begin
                y = v1[i];  // half adder
                z = 1'b0;
            end
            else if (i >= 4 && i <= 10)
            begin
                y = q7[i];
                z = v1[i] | v2[i];
            end
            else
            begin
                y = v1[i];
                z = v2[i];
            end
            fa = fullAdd(p7[i], y, z);
            s[i] = fa[0];
            c[i+1] = fa[1];
        end

        exactCols = {3'b111, mask};
        r = '0;
        r[1:0] = s[1:0];
        r[4:2] = s[4:2] | c[4:2];
        cy = 1'b0;
        for (int i = 5; i <= 14; i++)
        begin
            if (exactCols[i])
            begin
                fa = fullAdd(s[i], c[i], cy);
                r[i] = fa[0];
                cy = fa[1];
            end
            else
            begin
                r[i] = (s[i] ^ c[i]) | cy;
                cy = s[i] & (c[i] | cy);
            end
        end
        r[15] = cy;
        return r;
    endfunction

    function automatic logic [7:0] randByte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] want);
        checks++;
        if (got !== want)
        begin
            errors++;
            $display("ERROR %s: got 0x%0h, expected 0x%0h (cycle %0d)", name, got, want, cycles);
        end
    endtask

    // scoreboard capture and watchdog
    always @(posedge CLK)
    begin
        expEntryT entry;
        if (rstN && inValid)
        begin
            entry.expVal = refProduct(operandA, operandB, erMask);
            entry.zeroOp = (operandA == 8'h00) || (operandB == 8'h00);
            entry.tag = cycles;  // cycle in which the strobe was driven
            expQ.push_back(entry);
            inCount++;
        end
        cycles++;
        if (cycles >= timeoutLimit)
        begin
            $display("run timed out after %0d cycles, %0d results never arrived",
                     cycles, expQ.size());
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic scoreOutputs;
        expEntryT entry;
        if (!rstN)
            checkValue("outValid", 32'(outValid), 32'h0);
        else if (outValid)
        begin
            outCount++;  // every pulse, matched or not
            if (expQ.size() == 0)
            begin
                errors++;
                $display("outValid went high in cycle %0d with no operation in flight", cycles);
            end
            else
            begin
                if (expQ.size() > maxInFlight)
                    maxInFlight = expQ.size();
                entry = expQ.pop_front();
                checkValue("result", 32'(result), 32'(entry.expVal));
                checkValue("latency", cycles - entry.tag, `PIPE_DEPTH);
                if (entry.zeroOp)
                    checkValue("result", 32'(result), 32'h0);  // zero operand
            end
        end
    endtask

    task automatic tick;
        @(negedge CLK);
        scoreOutputs();
    endtask

    task automatic issue(input logic valid, input operandT a, input operandT b, input erMaskT m);
        tick();
        inValid = valid;
        operandA = a;
        operandB = b;
        erMask = m;
    endtask

    task automatic drain;
        tick();
        inValid = 1'b0;
        while (expQ.size() != 0)
            tick();
    endtask

    task automatic reportTest(input string name, input int ops, input int errBefore);
        $display("test %s: %0d ops, %0d errors", name, ops, errors - errBefore);
    endtask

    task automatic streamRandomOps;
        int errBefore;
        errBefore = errors;
        maxInFlight = 0;
        for (int n = 0; n < t1Ops; n++)
            issue(1'b1, randByte(), randByte(), erMaskT'(randByte()));
        drain();
        checkValue("operations in flight", maxInFlight, `PIPE_DEPTH);
        reportTest("random stream", t1Ops, errBefore);
    endtask

    task automatic alternateMasks;
        int      errBefore;
        operandT a;
        operandT b;
        errBefore = errors;
        for (int n = 0; n < t2Pairs; n++)
        begin
            a = randByte();
            b = randByte();
            issue(1'b1, a, b, '1);  // back to back with opposite masks
            issue(1'b1, a, b, '0);
        end
        drain();
        reportTest("exact vs approximate mask", 2*t2Pairs, errBefore);
    endtask

    task automatic zeroOperandOps;
        int      errBefore;
        operandT x;
        errBefore = errors;
        for (int n = 0; n < t3Ops; n++)
        begin
            x = randByte();
            if (n % 3 == 0)
                issue(1'b1, 8'h00, x, erMaskT'(randByte()));
            else if (n % 3 == 1)
                issue(1'b1, x, 8'h00, erMaskT'(randByte()));
            else
                issue(1'b1, 8'h00, 8'h00, erMaskT'(randByte()));
        end
        drain();
        reportTest("zero operand", t3Ops, errBefore);
    endtask

    task automatic sparseStrobes;
        int         errBefore;
        logic [7:0] r;
        errBefore = errors;
        inCount = 0;
        outCount = 0;
        for (int n = 0; n < t4Cycles; n++)
        begin
            r = randByte();
            issue(r[1:0] == 2'b00, randByte(), randByte(), erMaskT'(randByte()));
        end
        drain();
        checkValue("outValid count", outCount, inCount);
        reportTest("sparse strobes", inCount, errBefore);
    endtask

    task automatic midStreamReset;
        int errBefore;
        errBefore = errors;
        for (int n = 0; n < t5Ops; n++)
            issue(1'b1, randByte(), randByte(), erMaskT'(randByte()));
        tick();
        rstN = 1'b0;  // results in flight are lost
        inValid = 1'b0;
        expQ.delete();
        repeat (2) tick();
        rstN = 1'b1;
        repeat (3) tick();
        outCount = 0;
        issue(1'b1, randByte(), randByte(), erMaskT'(randByte()));
        drain();
        checkValue("outValid count after reset", outCount, 1);
        reportTest("mid-stream reset", t5Ops + 1, errBefore);
    endtask

    initial
    begin
        seed = 32'h50ba;
        rstN = 1'b0;
        inValid = 1'b0;
        operandA = '0;
        operandB = '0;
        erMask = '0;
        repeat (2) tick();
        rstN = 1'b1;

        streamRandomOps();
        alternateMasks();
        zeroOperandOps();
        sparseStrobes();
        midStreamReset();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- list.f
+incdir+include
logic/mulPkg.sv
logic/iCac.sv
logic/ppCompressor.sv
logic/csReducer.sv
logic/ecAdder.sv
logic/approxMultiplier.sv
tests/approxMultiplier_asserts.sv
tests/approxMultiplierTb.sv

//--- run.sh
#!/bin/sh
# build and run with Verilator; the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f list.f --top-module approxMultiplierTb \
    || { echo "build failed"; exit 1; }
./obj_dir/VapproxMultiplierTb 2>&1 | tee sim.log
grep -q "Simulation passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
